// File: bench/clock_gen.sv
/*
 * Testbench clock and power-on reset.
 * 40 ns period; rst_n is low for the first 5 rising edges.
 */
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: bench/proc_asserts.sv
/*
 * Protocol checks bound to the proc top level.
 * All properties are disabled while rst_n is low.
 */
`timescale 1ns/10ps

module proc_asserts (
	input logic clk,
	input logic rst_n,
	input proc_pkg::word_t imem_addr,
	input proc_pkg::dmem_req_t dmem_req,
	input logic halted,
	input logic err
);

	// A stopped core must not touch data memory
	no_dmem_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !dmem_req.valid)
		else $error("data memory request while halted");

	halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted fell without reset");

	err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		err |=> err)
		else $error("err fell without reset");

	imem_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(imem_addr))
		else $error("imem_addr is unknown");

endmodule

bind proc proc_asserts u_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.imem_addr (imem_addr),
	.dmem_req  (dmem_req),
	.halted    (halted),
	.err       (err)
);

// File: bench/proc_tb.sv
/*
 * Directed tests for the pipelined core.
 * Registers have no reset, so each program zeroes r0 with XOR first
 * (exact in a two-state simulator). Memories hold 256 words each.
 */
`timescale 1ns/10ps
`include "proc_defs.svh"

module proc_tb;

	logic clk;
	logic gen_rst_n;
	logic tb_rst_n;
	logic rst_n;
	proc_pkg::word_t imem_addr;
	proc_pkg::word_t imem_data;
	proc_pkg::dmem_req_t dmem_req;
	proc_pkg::word_t dmem_rdata;
	logic halted;
	logic err;
	proc_pkg::word_t imem [256];
	proc_pkg::word_t dmem [256];
	integer seed;
	integer errors;
	integer checks;
	integer wr_ptr;

	clock_gen u_clk (.clk(clk), .rst_n(gen_rst_n));

	assign rst_n = gen_rst_n && tb_rst_n;

	proc u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.halted     (halted),
		.err        (err)
	);

	// Both memories answer in the same cycle
	assign imem_data = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem[dmem_req.addr[7:0]];

	always @(posedge clk) begin
		if (dmem_req.valid && dmem_req.we)
			dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
	end

	function automatic proc_pkg::word_t fill_value(input integer a);
		return {a[7:0] ^ 8'h5a, ~a[7:0]};
	endfunction

	function automatic proc_pkg::word_t sext6(input logic [5:0] v);
		return {{10{v[5]}}, v};
	endfunction

	function automatic proc_pkg::word_t rtype_word(input logic [3:0] op,
		input int rd, input int rs, input int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
	endfunction

	function automatic proc_pkg::word_t imm_word(input logic [3:0] op,
		input int rd, input int rs, input logic [5:0] imm);
		return {op, rd[2:0], rs[2:0], imm};
	endfunction

	task automatic emit(input proc_pkg::word_t w);
		imem[wr_ptr] = w;
		wr_ptr = wr_ptr + 1;
	endtask

	// Reset the core and clear both memories for a new program
	task automatic begin_reset();
		@(posedge clk);
		tb_rst_n <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < 256; i++) begin
			imem[i] = {`OP_NOP, 12'h000};
			dmem[i] <= fill_value(i);
		end
		wr_ptr = 0;
	endtask

	task automatic end_reset();
		repeat (4) @(posedge clk);
		tb_rst_n <= 1'b1;
	endtask

	task automatic wait_halted(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!halted && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("%s: core did not halt within 200 cycles", name);
		end
	endtask

	task automatic check_word(input int a, input proc_pkg::word_t exp, input string name);
		checks++;
		assert (dmem[a] === exp)
		else begin
			errors++;
			$display("ERROR @%0t: %s dmem[%0d] = %h, expected %h",
				$time, name, a, dmem[a], exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("ERROR @%0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Chain of dependent ALU operations stored to 8..13
	task automatic test_alu_forwarding();
		logic [5:0] i1;
		logic [5:0] i2;
		proc_pkg::word_t r [7];
		i1 = $random(seed);
		i2 = $random(seed);
		begin_reset();
		emit(rtype_word(`OP_XOR, 0, 0, 0));
		emit(imm_word(`OP_ADDI, 1, 0, i1));
		emit(imm_word(`OP_ADDI, 2, 1, i2));
		emit(rtype_word(`OP_ADD, 3, 2, 1));
		emit(rtype_word(`OP_SUB, 4, 3, 2));
		emit(rtype_word(`OP_AND, 5, 4, 3));
		emit(rtype_word(`OP_XOR, 6, 5, 4));
		for (int k = 1; k <= 6; k++)
			emit(imm_word(`OP_ST, k, 0, 6'(7 + k)));
		emit({`OP_HALT, 12'h000});
		end_reset();
		r[1] = sext6(i1);
		r[2] = r[1] + sext6(i2);
		r[3] = r[2] + r[1];
		r[4] = r[3] - r[2];
		r[5] = r[4] & r[3];
		r[6] = r[5] ^ r[4];
		wait_halted("alu");
		for (int k = 1; k <= 6; k++)
			check_word(7 + k, r[k], "alu chain");
	endtask

	task automatic test_load_use();
		logic [5:0] v;
		logic [5:0] k;
		v = $random(seed);
		k = $random(seed);
		begin_reset();
		emit(rtype_word(`OP_XOR, 0, 0, 0));
		emit(imm_word(`OP_ADDI, 1, 0, v));
		emit(imm_word(`OP_ST, 1, 0, 6'd20));
		emit(imm_word(`OP_LD, 2, 0, 6'd20));
		emit(imm_word(`OP_ADDI, 3, 2, k));
		emit(imm_word(`OP_ST, 3, 0, 6'd21));
		emit({`OP_HALT, 12'h000});
		end_reset();
		wait_halted("load-use");
		check_word(20, sext6(v), "load-use store");
		check_word(21, sext6(v) + sext6(k), "load-use result");
	endtask

	task automatic test_branches();
		begin_reset();
		emit(rtype_word(`OP_XOR, 0, 0, 0));
		emit(imm_word(`OP_ADDI, 1, 0, 6'd7));
		// Taken branch lands on the third word after it
		emit(imm_word(`OP_BEQZ, 0, 0, 6'd2));
		emit(imm_word(`OP_ST, 1, 0, 6'd25));
		emit(imm_word(`OP_ST, 1, 0, 6'd26));
		emit(imm_word(`OP_ST, 1, 0, 6'd24));
		emit(imm_word(`OP_BEQZ, 0, 1, 6'd1));
		emit(imm_word(`OP_ST, 1, 0, 6'd27));
		emit({`OP_HALT, 12'h000});
		end_reset();
		wait_halted("branch");
		check_word(24, 16'd7, "branch target");
		check_word(25, fill_value(25), "flushed store");
		check_word(26, fill_value(26), "flushed store");
		check_word(27, 16'd7, "not-taken store");
	endtask

	task automatic run_halt_program(input string name);
		begin_reset();
		emit(rtype_word(`OP_XOR, 0, 0, 0));
		emit(imm_word(`OP_ADDI, 1, 0, 6'd9));
		emit(imm_word(`OP_ST, 1, 0, 6'd16));
		emit({`OP_HALT, 12'h000});
		emit(imm_word(`OP_ST, 1, 0, 6'd17));
		end_reset();
		wait_halted(name);
		check_flag(err, 1'b0, "err");
		check_word(16, 16'd9, "store before halt");
		check_word(17, fill_value(17), "store after halt");
	endtask

	task automatic test_illegal();
		begin_reset();
		emit(rtype_word(`OP_XOR, 0, 0, 0));
		emit(imm_word(`OP_ADDI, 1, 0, 6'd3));
		emit(16'hf000);
		emit(imm_word(`OP_ST, 1, 0, 6'd18));
		emit({`OP_HALT, 12'h000});
		end_reset();
		wait_halted("illegal");
		check_flag(err, 1'b1, "err");
		check_word(18, fill_value(18), "store after illegal");
		begin_reset();
		@(negedge clk);
		check_flag(err, 1'b0, "err in reset");
		check_flag(halted, 1'b0, "halted in reset");
		end_reset();
		run_halt_program("after illegal");
	endtask

	initial begin
		seed = 72;
		errors = 0;
		checks = 0;
		wr_ptr = 0;
		tb_rst_n = 1'b0;
		test_alu_forwarding();
		test_load_use();
		test_branches();
		run_halt_program("halt");
		test_illegal();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/proc_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory_stage.sv
logic/proc.sv
bench/clock_gen.sv
bench/proc_asserts.sv
bench/proc_tb.sv

// File: logic/decode.sv
/*
 * Decode stage with the register file and hazard control.
 * Register writes from mem_wb land at the edge and are bypassed to
 * same-cycle reads. A load in execute feeding this instruction costs
 * one bubble. HALT or an illegal opcode stops issue until reset.
 */
`timescale 1ns/10ps
`include "proc_defs.svh"

module decode (
	input logic clk,
	input logic rst_n,
	input proc_pkg::if_id_t if_id,
	input proc_pkg::redirect_t redirect,
	input proc_pkg::id_ex_t id_ex_cur,
	input proc_pkg::mem_wb_t mem_wb,
	output logic hold,
	output proc_pkg::id_ex_t id_ex,
	output logic err
);

	proc_pkg::word_t regs [`PROC_NREGS];
	logic [3:0] opcode;
	proc_pkg::reg_idx_t rs;
	proc_pkg::reg_idx_t rt;
	proc_pkg::reg_idx_t rd;
	proc_pkg::word_t imm;
	proc_pkg::id_ex_t ctl;
	logic uses_rs;
	logic uses_rt;
	logic illegal;
	logic wb_wr;
	logic load_use;
	logic stopping;
	logic issue;
	logic stop;

	assign opcode = if_id.instr[15:12];
	assign rd = if_id.instr[11:9];
	assign rs = if_id.instr[8:6];
	// ST names its data register in the rd field
	assign rt = (opcode == `OP_ST) ? if_id.instr[11:9] : if_id.instr[5:3];
	assign imm = {{(`PROC_XLEN - 6){if_id.instr[5]}}, if_id.instr[5:0]};

	assign wb_wr = mem_wb.valid && mem_wb.reg_wr;

	always_ff @(posedge clk) begin
		if (wb_wr)
			regs[mem_wb.rd] <= mem_wb.data;
	end

	always_comb begin
		ctl = '0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		illegal = 1'b0;
		ctl.pc = if_id.pc;
		ctl.imm = imm;
		ctl.rs = rs;
		ctl.rt = rt;
		ctl.rd = rd;
		ctl.rs_val = (wb_wr && mem_wb.rd == rs) ? mem_wb.data : regs[rs];
		ctl.rt_val = (wb_wr && mem_wb.rd == rt) ? mem_wb.data : regs[rt];
		case (opcode)
			`OP_SUB: ctl.alu_op = `ALU_SUB;
			`OP_AND: ctl.alu_op = `ALU_AND;
			`OP_XOR: ctl.alu_op = `ALU_XOR;
			default: ctl.alu_op = `ALU_ADD;
		endcase
		case (opcode)
			`OP_NOP: ;
			`OP_ADD, `OP_SUB, `OP_AND, `OP_XOR: begin
				ctl.reg_wr = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			`OP_ADDI, `OP_LD: begin
				ctl.use_imm = 1'b1;
				ctl.reg_wr = 1'b1;
				ctl.mem_rd = (opcode == `OP_LD);
				uses_rs = 1'b1;
			end
			`OP_ST: begin
				ctl.use_imm = 1'b1;
				ctl.mem_wr = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			`OP_BEQZ: begin
				ctl.branch = 1'b1;
				uses_rs = 1'b1;
			end
			`OP_HALT: ctl.halt = 1'b1;
			default: begin
				// Retires like HALT
				illegal = 1'b1;
				ctl.halt = 1'b1;
			end
		endcase
	end

	assign load_use = if_id.valid && id_ex_cur.valid && id_ex_cur.mem_rd &&
		((uses_rs && id_ex_cur.rd == rs) || (uses_rt && id_ex_cur.rd == rt));
	assign stopping = if_id.valid && ctl.halt;
	assign hold = load_use || stop || stopping;
	assign issue = if_id.valid && !stop && !load_use && !redirect.valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
			stop <= 1'b0;
			err <= 1'b0;
		end else begin
			id_ex <= ctl;
			id_ex.valid <= issue;
			if (issue && stopping) begin
				stop <= 1'b1;
				err <= err || illegal;
			end
		end
	end

endmodule

// File: logic/execute.sv
/*
 * Execute stage. Operands forward from ex_mem first, then mem_wb.
 * A load result never has to forward from ex_mem since decode
 * stalls its consumer by one cycle.
 * BEQZ resolves here and redirects for exactly one cycle.
 */
`timescale 1ns/10ps
`include "proc_defs.svh"

module execute (
	input logic clk,
	input logic rst_n,
	input proc_pkg::id_ex_t id_ex,
	input proc_pkg::mem_wb_t mem_wb,
	output proc_pkg::ex_mem_t ex_mem,
	output proc_pkg::redirect_t redirect
);

	proc_pkg::word_t op_a;
	proc_pkg::word_t op_rt;
	proc_pkg::word_t op_b;
	proc_pkg::word_t alu_out;
	logic taken;

	// Youngest producer wins
	function automatic proc_pkg::word_t fwd(
		input proc_pkg::reg_idx_t idx,
		input proc_pkg::word_t val,
		input proc_pkg::ex_mem_t em,
		input proc_pkg::mem_wb_t mw
	);
		if (em.valid && em.reg_wr && em.rd == idx)
			return em.result;
		if (mw.valid && mw.reg_wr && mw.rd == idx)
			return mw.data;
		return val;
	endfunction

	assign op_a = fwd(id_ex.rs, id_ex.rs_val, ex_mem, mem_wb);
	assign op_rt = fwd(id_ex.rt, id_ex.rt_val, ex_mem, mem_wb);
	assign op_b = id_ex.use_imm ? id_ex.imm : op_rt;

	always_comb begin
		case (id_ex.alu_op)
			`ALU_SUB: alu_out = op_a - op_b;
			`ALU_AND: alu_out = op_a & op_b;
			`ALU_XOR: alu_out = op_a ^ op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	assign taken = id_ex.valid && id_ex.branch && (op_a == '0);
	assign redirect.valid = taken;
	assign redirect.target = id_ex.pc + proc_pkg::word_t'(1) + id_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.reg_wr <= id_ex.reg_wr;
			ex_mem.mem_rd <= id_ex.mem_rd;
			ex_mem.mem_wr <= id_ex.mem_wr;
			ex_mem.rd <= id_ex.rd;
			ex_mem.result <= alu_out;
			ex_mem.store_data <= op_rt;
			ex_mem.halt <= id_ex.halt;
		end
	end

endmodule

// File: logic/fetch.sv
/*
 * Fetch stage. The instruction memory must answer imem_addr in the
 * same cycle; there is no wait state.
 * A redirect takes priority over hold.
 */
`timescale 1ns/10ps
`include "proc_defs.svh"

module fetch (
	input logic clk,
	input logic rst_n,
	input logic hold,
	input proc_pkg::redirect_t redirect,
	output proc_pkg::word_t imem_addr,
	input proc_pkg::word_t imem_data,
	output proc_pkg::if_id_t if_id
);

	proc_pkg::word_t pc;

	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `PROC_RESET_PC;
			if_id <= '0;
		end else if (redirect.valid) begin
			// Taken branch drops the wrong-path word
			pc <= redirect.target;
			if_id.valid <= 1'b0;
		end else if (!hold) begin
			pc <= pc + proc_pkg::word_t'(1);
			if_id.valid <= 1'b1;
			if_id.pc <= pc;
			if_id.instr <= imem_data;
		end
	end

endmodule

// File: logic/memory_stage.sv
/*
 * Memory stage. Loads expect dmem_rdata in the same cycle as the
 * request; stores commit at the next rising edge.
 * halted rises when HALT reaches writeback and holds until reset.
 */
`timescale 1ns/10ps

module memory_stage (
	input logic clk,
	input logic rst_n,
	input proc_pkg::ex_mem_t ex_mem,
	output proc_pkg::dmem_req_t dmem_req,
	input proc_pkg::word_t dmem_rdata,
	output proc_pkg::mem_wb_t mem_wb,
	output logic halted
);

	proc_pkg::word_t wb_data;

	assign dmem_req.valid = ex_mem.valid && (ex_mem.mem_rd || ex_mem.mem_wr);
	assign dmem_req.we = ex_mem.valid && ex_mem.mem_wr;
	assign dmem_req.addr = ex_mem.result;
	assign dmem_req.wdata = ex_mem.store_data;

	// Load data or ALU result
	assign wb_data = ex_mem.mem_rd ? dmem_rdata : ex_mem.result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
			halted <= 1'b0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
			mem_wb.reg_wr <= ex_mem.reg_wr;
			mem_wb.rd <= ex_mem.rd;
			mem_wb.data <= wb_data;
			mem_wb.halt <= ex_mem.halt;
			if (mem_wb.valid && mem_wb.halt)
				halted <= 1'b1;
		end
	end

endmodule

// File: logic/proc.sv
/*
 * Top of the five-stage 16-bit core.
 * Both memories sit outside and must answer combinationally.
 * After halted or err rises, only reset restarts the core.
 */
`timescale 1ns/10ps

module proc (
	input logic clk,
	input logic rst_n,
	output proc_pkg::word_t imem_addr,
	input proc_pkg::word_t imem_data,
	output proc_pkg::dmem_req_t dmem_req,
	input proc_pkg::word_t dmem_rdata,
	output logic halted,
	output logic err
);

	proc_pkg::if_id_t if_id;
	proc_pkg::id_ex_t id_ex;
	proc_pkg::ex_mem_t ex_mem;
	proc_pkg::mem_wb_t mem_wb;
	proc_pkg::redirect_t redirect;
	logic hold;

	fetch u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.hold      (hold),
		.redirect  (redirect),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.if_id     (if_id)
	);

	// id_ex also feeds back for the load-use check
	decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.if_id     (if_id),
		.redirect  (redirect),
		.id_ex_cur (id_ex),
		.mem_wb    (mem_wb),
		.hold      (hold),
		.id_ex     (id_ex),
		.err       (err)
	);

	execute u_execute (
		.clk      (clk),
		.rst_n    (rst_n),
		.id_ex    (id_ex),
		.mem_wb   (mem_wb),
		.ex_mem   (ex_mem),
		.redirect (redirect)
	);

	memory_stage u_memory_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_mem     (ex_mem),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.mem_wb     (mem_wb),
		.halted     (halted)
	);

endmodule

// File: logic/proc_defs.svh
/*
 * Widths, reset vector and encodings of the 16-bit pipelined core.
 * Opcodes live in instr[15:12]. Any code not listed here is illegal.
 * ALU codes are internal to the pipeline and never appear in an instruction.
 */
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

`define PROC_XLEN     16
`define PROC_NREGS    8
`define PROC_RESET_PC 16'h0000

// Opcodes
`define OP_NOP  4'h0
`define OP_ADD  4'h1
`define OP_SUB  4'h2
`define OP_AND  4'h3
`define OP_XOR  4'h4
`define OP_ADDI 4'h5
`define OP_LD   4'h6
`define OP_ST   4'h7
`define OP_BEQZ 4'h8
`define OP_HALT 4'h9

// ALU operations
`define ALU_ADD 2'd0
`define ALU_SUB 2'd1
`define ALU_AND 2'd2
`define ALU_XOR 2'd3

`endif

// File: logic/proc_pkg.sv
/*
 * Types shared by the pipeline stages.
 * One packed struct per pipeline boundary; payload fields are only
 * meaningful while the struct's valid bit is set.
 */
`include "proc_defs.svh"

package proc_pkg;

	typedef logic [`PROC_XLEN-1:0] word_t;
	typedef logic [$clog2(`PROC_NREGS)-1:0] reg_idx_t;
	typedef logic [1:0] alu_op_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		alu_op_t alu_op;
		logic use_imm;
		word_t imm;
		reg_idx_t rs;
		// For ST this is the register holding the store data
		reg_idx_t rt;
		reg_idx_t rd;
		word_t rs_val;
		word_t rt_val;
		logic reg_wr;
		logic mem_rd;
		logic mem_wr;
		logic branch;
		logic halt;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic reg_wr;
		logic mem_rd;
		logic mem_wr;
		reg_idx_t rd;
		word_t result;
		word_t store_data;
		logic halt;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		logic reg_wr;
		reg_idx_t rd;
		word_t data;
		logic halt;
	} mem_wb_t;

	typedef struct packed {
		logic valid;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		logic we;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module proc_tb
output=$(./obj_dir/Vproc_tb)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "All tests passed!"
